// ==== rv_exec_defs.svh ====
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// ============================================================
// rv32i widths
// ============================================================

// data word
`define RV_XLEN 32

// instruction word
`define RV_ILEN 32

// register address, x0 to x31
`define RV_REG_AW 5

`endif

// ==== rv_exec_pkg.sv ====
`include "rv_exec_defs.svh"

package rv_exec_pkg;

    // major opcodes of the covered groups
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // same encoding as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {sel_a_rs1, sel_a_pc, sel_a_zero} op_a_sel_e;

    typedef enum logic [1:0] {sel_b_rs2, sel_b_imm, sel_b_four} op_b_sel_e;

    typedef struct packed {
        opcode_e                opcode;
        alu_op_e                alu_op;
        cmp_op_e                cmp_op;
        op_a_sel_e              a_sel;
        op_b_sel_e              b_sel;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   we;
        logic [`RV_XLEN-1:0]    imm;
        logic                   is_branch;
        logic                   is_jump;
        logic                   target_from_rs1;
        logic                   illegal;
    } decoded_t;

endpackage

// ==== rv_exec_if.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

// ============================================================
// register file read port, decode to result
// ============================================================
interface rv_rf_if;
    logic [`RV_REG_AW-1:0] raddr1;
    logic [`RV_REG_AW-1:0] raddr2;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;

    modport requester (output raddr1, raddr2, input rdata1, rdata2);
    modport provider  (input raddr1, raddr2, output rdata1, rdata2);
endinterface

// decoded instruction, decode to execute
interface rv_dec_if;
    logic                   valid;
    logic                   ready;
    logic [`RV_XLEN-1:0]    pc;
    rv_exec_pkg::decoded_t  item;
    logic [`RV_XLEN-1:0]    rs1_val;
    logic [`RV_XLEN-1:0]    rs2_val;

    modport source (output valid, pc, item, rs1_val, rs2_val, input ready);
    modport sink   (input valid, pc, item, rs1_val, rs2_val, output ready);
endinterface

// finished result, execute to result
interface rv_res_if;
    logic                  valid;
    logic                  ready;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic                  we;
    logic [`RV_XLEN-1:0]   value;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   target;
    logic                  illegal;

    modport source (output valid, pc, rd, we, value, redirect, target, illegal,
                    input ready);
    modport sink   (input valid, pc, rd, we, value, redirect, target, illegal,
                    output ready);
endinterface

// ============================================================
// forwarding, result back to execute
// ============================================================
interface rv_fwd_if;
    logic                  slot_valid;
    logic [`RV_REG_AW-1:0] slot_rd;
    logic                  slot_we;
    logic [`RV_XLEN-1:0]   slot_value;
    logic                  wb_valid;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic                  wb_we;
    logic [`RV_XLEN-1:0]   wb_value;

    modport producer (output slot_valid, slot_rd, slot_we, slot_value,
                      output wb_valid, wb_rd, wb_we, wb_value);
    modport consumer (input slot_valid, slot_rd, slot_we, slot_value,
                      input wb_valid, wb_rd, wb_we, wb_value);
endinterface

// ==== rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`RV_ILEN-1:0] in_instr,
    input  logic [`RV_XLEN-1:0] in_pc,
    rv_rf_if.requester          rf,
    rv_dec_if.source            dec
);

    logic [6:0]            funct7;
    logic [2:0]            funct3;
    logic [`RV_XLEN-1:0]   imm_i, imm_u, imm_b, imm_j;
    rv_exec_pkg::decoded_t dcd;

    logic                  run_q;
    logic                  valid_q;
    rv_exec_pkg::decoded_t item_q;
    logic [`RV_XLEN-1:0]   pc_q, rs1_q, rs2_q;

    function automatic rv_exec_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_of = alt ? rv_exec_pkg::alu_sub : rv_exec_pkg::alu_add;
            3'b001:  alu_of = rv_exec_pkg::alu_sll;
            3'b010:  alu_of = rv_exec_pkg::alu_slt;
            3'b011:  alu_of = rv_exec_pkg::alu_sltu;
            3'b100:  alu_of = rv_exec_pkg::alu_xor;
            3'b101:  alu_of = alt ? rv_exec_pkg::alu_sra : rv_exec_pkg::alu_srl;
            3'b110:  alu_of = rv_exec_pkg::alu_or;
            default: alu_of = rv_exec_pkg::alu_and;
        endcase
    endfunction

    assign funct7 = in_instr[31:25];
    assign funct3 = in_instr[14:12];

    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
    assign imm_u = {in_instr[31:12], 12'b0};
    assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7], in_instr[30:25],
                    in_instr[11:8], 1'b0};
    assign imm_j = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12], in_instr[20],
                    in_instr[30:21], 1'b0};

    // ============================================================
    // field decode
    // ============================================================
    always_comb begin
        dcd                 = '0;
        dcd.opcode          = rv_exec_pkg::opcode_e'(in_instr[6:0]);
        dcd.alu_op          = rv_exec_pkg::alu_add;
        dcd.cmp_op          = rv_exec_pkg::cmp_op_e'(funct3);
        dcd.a_sel           = rv_exec_pkg::sel_a_rs1;
        dcd.b_sel           = rv_exec_pkg::sel_b_imm;
        dcd.rs1             = in_instr[19:15];
        dcd.rs2             = in_instr[24:20];
        dcd.rd              = in_instr[11:7];
        case (dcd.opcode)
            rv_exec_pkg::opc_lui: begin
                dcd.a_sel = rv_exec_pkg::sel_a_zero;
                dcd.imm   = imm_u;
                dcd.we    = 1'b1;
            end
            rv_exec_pkg::opc_auipc: begin
                dcd.a_sel = rv_exec_pkg::sel_a_pc;
                dcd.imm   = imm_u;
                dcd.we    = 1'b1;
            end
            rv_exec_pkg::opc_jal, rv_exec_pkg::opc_jalr: begin
                // link value pc+4 comes out of the alu
                dcd.a_sel           = rv_exec_pkg::sel_a_pc;
                dcd.b_sel           = rv_exec_pkg::sel_b_four;
                dcd.is_jump         = 1'b1;
                dcd.we              = 1'b1;
                dcd.target_from_rs1 = (dcd.opcode == rv_exec_pkg::opc_jalr);
                dcd.imm             = dcd.target_from_rs1 ? imm_i : imm_j;
                dcd.illegal         = dcd.target_from_rs1 && funct3 != 3'b000;
            end
            rv_exec_pkg::opc_branch: begin
                dcd.imm       = imm_b;
                dcd.is_branch = 1'b1;
                dcd.illegal   = funct3[2:1] == 2'b01;
            end
            rv_exec_pkg::opc_op_imm: begin
                dcd.imm     = imm_i;
                dcd.we      = 1'b1;
                dcd.alu_op  = alu_of(funct3, funct3 == 3'b101 && funct7[5]);
                dcd.illegal = (funct3 == 3'b001 && funct7 != 7'h00) ||
                              (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20);
            end
            rv_exec_pkg::opc_op: begin
                dcd.b_sel   = rv_exec_pkg::sel_b_rs2;
                dcd.we      = 1'b1;
                dcd.alu_op  = alu_of(funct3, funct7[5]);
                dcd.illegal = !(funct7 == 7'h00 ||
                                (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: dcd.illegal = 1'b1;
        endcase
        // is_branch and is_jump drop too, so an illegal word never redirects
        if (dcd.illegal) begin
            dcd.is_branch = 1'b0;
            dcd.is_jump   = 1'b0;
        end
        dcd.we = dcd.we && !dcd.illegal && dcd.rd != '0;
    end

    assign rf.raddr1 = in_instr[19:15];
    assign rf.raddr2 = in_instr[24:20];

    // ============================================================
    // pipeline register
    // ============================================================
    assign in_ready = run_q && (!valid_q || dec.ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (in_ready)
                valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            item_q <= dcd;
            pc_q   <= in_pc;
            rs1_q  <= rf.rdata1;
            rs2_q  <= rf.rdata2;
        end
    end

    assign dec.valid   = valid_q;
    assign dec.item    = item_q;
    assign dec.pc      = pc_q;
    assign dec.rs1_val = rs1_q;
    assign dec.rs2_val = rs2_q;

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_alu (
    input  rv_exec_pkg::alu_op_e alu_op,
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    output logic [`RV_XLEN-1:0]  y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            rv_exec_pkg::alu_add:  y = a + b;
            rv_exec_pkg::alu_sub:  y = a - b;
            rv_exec_pkg::alu_sll:  y = a << shamt;
            rv_exec_pkg::alu_slt:  y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_exec_pkg::alu_sltu: y = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_exec_pkg::alu_xor:  y = a ^ b;
            rv_exec_pkg::alu_srl:  y = a >> shamt;
            // sign fill from bit 31
            rv_exec_pkg::alu_sra:  y = $signed(a) >>> shamt;
            rv_exec_pkg::alu_or:   y = a | b;
            rv_exec_pkg::alu_and:  y = a & b;
            default:               y = '0;
        endcase
    end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_execute (
    rv_dec_if.sink     dec,
    rv_fwd_if.consumer fwd,
    rv_res_if.source   res
);

    logic [`RV_XLEN-1:0] rs1_v, rs2_v;
    logic [`RV_XLEN-1:0] alu_a, alu_b, alu_y;
    logic [`RV_XLEN-1:0] base, sum;
    logic                taken;

    // held result first, then the last retired one, then the decode read
    function automatic logic [`RV_XLEN-1:0] fwd_pick(input logic [`RV_REG_AW-1:0] rs,
                                                    input logic [`RV_XLEN-1:0] rf_val);
        if (rs != '0 && fwd.slot_valid && fwd.slot_we && fwd.slot_rd == rs)
            fwd_pick = fwd.slot_value;
        else if (rs != '0 && fwd.wb_valid && fwd.wb_we && fwd.wb_rd == rs)
            fwd_pick = fwd.wb_value;
        else
            fwd_pick = rf_val;
    endfunction

    always_comb begin
        rs1_v = fwd_pick(dec.item.rs1, dec.rs1_val);
        rs2_v = fwd_pick(dec.item.rs2, dec.rs2_val);
    end

    // ============================================================
    // operand muxes and alu
    // ============================================================
    always_comb begin
        case (dec.item.a_sel)
            rv_exec_pkg::sel_a_pc:   alu_a = dec.pc;
            rv_exec_pkg::sel_a_zero: alu_a = '0;
            default:                 alu_a = rs1_v;
        endcase
        case (dec.item.b_sel)
            rv_exec_pkg::sel_b_imm:  alu_b = dec.item.imm;
            rv_exec_pkg::sel_b_four: alu_b = `RV_XLEN'd4;
            default:                 alu_b = rs2_v;
        endcase
    end

    rv_alu u_rv_alu (
        .alu_op (dec.item.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .y      (alu_y)
    );

    // branch compare
    always_comb begin
        case (dec.item.cmp_op)
            rv_exec_pkg::cmp_beq:  taken = rs1_v == rs2_v;
            rv_exec_pkg::cmp_bne:  taken = rs1_v != rs2_v;
            rv_exec_pkg::cmp_blt:  taken = $signed(rs1_v) < $signed(rs2_v);
            rv_exec_pkg::cmp_bge:  taken = $signed(rs1_v) >= $signed(rs2_v);
            rv_exec_pkg::cmp_bltu: taken = rs1_v < rs2_v;
            rv_exec_pkg::cmp_bgeu: taken = rs1_v >= rs2_v;
            default:               taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the target
    assign base = dec.item.target_from_rs1 ? rs1_v : dec.pc;
    assign sum  = base + dec.item.imm;

    assign res.valid    = dec.valid;
    assign dec.ready    = res.ready;
    assign res.pc       = dec.pc;
    assign res.rd       = dec.item.rd;
    assign res.we       = dec.item.we;
    assign res.value    = alu_y;
    assign res.redirect = dec.item.is_jump || (dec.item.is_branch && taken);
    assign res.target   = {sum[`RV_XLEN-1:1], sum[0] & ~dec.item.target_from_rs1};
    assign res.illegal  = dec.item.illegal;

endmodule

// ==== rv_result.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_result (
    input  logic                  clk,
    input  logic                  rst_n,
    rv_res_if.sink                res,
    rv_fwd_if.producer            fwd,
    rv_rf_if.provider             rf,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [`RV_XLEN-1:0]   out_pc,
    output logic [`RV_XLEN-1:0]   out_value,
    output logic [`RV_XLEN-1:0]   out_target,
    output logic [`RV_REG_AW-1:0] out_rd,
    output logic                  out_we,
    output logic                  out_redirect,
    output logic                  out_illegal
);

    logic                  slot_q;
    logic                  leave;
    logic [`RV_XLEN-1:0]   pc_q, value_q, target_q;
    logic [`RV_REG_AW-1:0] rd_q;
    logic                  we_q, redirect_q, illegal_q;

    // x0 is not stored
    logic [`RV_XLEN-1:0]   regs [1:31];

    logic                  wb_q;
    logic [`RV_REG_AW-1:0] wb_rd_q;
    logic                  wb_we_q;
    logic [`RV_XLEN-1:0]   wb_value_q;

    // write-through for the register leaving this cycle
    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0)
            rf_read = '0;
        else if (leave && we_q && rd_q == addr)
            rf_read = value_q;
        else
            rf_read = regs[addr];
    endfunction

    assign leave     = slot_q && out_ready;
    assign res.ready = !slot_q || out_ready;

    // ============================================================
    // result slot
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            slot_q <= 1'b0;
        else if (res.ready)
            slot_q <= res.valid;
    end

    always_ff @(posedge clk) begin
        if (res.valid && res.ready) begin
            pc_q       <= res.pc;
            rd_q       <= res.rd;
            we_q       <= res.we;
            value_q    <= res.value;
            redirect_q <= res.redirect;
            target_q   <= res.target;
            illegal_q  <= res.illegal;
        end
    end

    // ============================================================
    // register file and last retired record
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (leave && we_q) begin
            regs[rd_q] <= value_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_q <= 1'b0;
        else if (leave)
            wb_q <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (leave) begin
            wb_rd_q    <= rd_q;
            wb_we_q    <= we_q;
            wb_value_q <= value_q;
        end
    end

    always_comb begin
        rf.rdata1 = rf_read(rf.raddr1);
        rf.rdata2 = rf_read(rf.raddr2);
    end

    assign fwd.slot_valid = slot_q;
    assign fwd.slot_rd    = rd_q;
    assign fwd.slot_we    = we_q;
    assign fwd.slot_value = value_q;
    assign fwd.wb_valid   = wb_q;
    assign fwd.wb_rd      = wb_rd_q;
    assign fwd.wb_we      = wb_we_q;
    assign fwd.wb_value   = wb_value_q;

    assign out_valid    = slot_q;
    assign out_pc       = pc_q;
    assign out_value    = value_q;
    assign out_target   = target_q;
    assign out_rd       = rd_q;
    assign out_we       = we_q;
    assign out_redirect = redirect_q;
    assign out_illegal  = illegal_q;

endmodule

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_exec_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`RV_ILEN-1:0]   in_instr,
    input  logic [`RV_XLEN-1:0]   in_pc,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [`RV_XLEN-1:0]   out_pc,
    output logic [`RV_REG_AW-1:0] out_rd,
    output logic                  out_we,
    output logic [`RV_XLEN-1:0]   out_value,
    output logic                  out_redirect,
    output logic [`RV_XLEN-1:0]   out_target,
    output logic                  out_illegal
);

    rv_rf_if  rf_bus ();
    rv_dec_if dec_bus ();
    rv_res_if res_bus ();
    rv_fwd_if fwd_bus ();

    // decode -> execute -> result, forwarding loops back from result
    rv_decode u_rv_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .rf       (rf_bus.requester),
        .dec      (dec_bus.source)
    );

    rv_execute u_rv_execute (
        .dec (dec_bus.sink),
        .fwd (fwd_bus.consumer),
        .res (res_bus.source)
    );

    rv_result u_rv_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (res_bus.sink),
        .fwd          (fwd_bus.producer),
        .rf           (rf_bus.provider),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_value    (out_value),
        .out_target   (out_target),
        .out_rd       (out_rd),
        .out_we       (out_we),
        .out_redirect (out_redirect),
        .out_illegal  (out_illegal)
    );

endmodule

// ==== rv_exec_asserts.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_exec_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic [`RV_XLEN-1:0]   out_pc,
    input logic [`RV_XLEN-1:0]   out_value,
    input logic [`RV_XLEN-1:0]   out_target,
    input logic [`RV_REG_AW-1:0] out_rd,
    input logic                  out_we,
    input logic                  out_redirect,
    input logic                  out_illegal
);

    int unsigned fails = 0;

    a_out_valid_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fails++;
            $error("out_valid high during reset");
        end

    a_in_ready_reset: assert property (@(posedge clk) !rst_n |-> !in_ready)
        else begin
            fails++;
            $error("in_ready high during reset");
        end

    // held output stays put until taken
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid &&
            $stable({out_pc, out_rd, out_we, out_value, out_redirect, out_target, out_illegal}))
        else begin
            fails++;
            $error("output changed while stalled");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(out_we && out_rd == '0))
        else begin
            fails++;
            $error("write to x0 reported");
        end

endmodule

// ==== rv_exec_tb.sv ====
`timescale 1ns/1ps
`include "rv_exec_defs.svh"

module rv_exec_tb;

    localparam int NUM_INSTR = 400;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;
        logic [`RV_XLEN-1:0]   value;
        logic                  redirect;
        logic [`RV_XLEN-1:0]   target;
        logic                  illegal;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    logic [`RV_ILEN-1:0]   in_instr;
    logic [`RV_XLEN-1:0]   in_pc;
    logic                  out_valid;
    logic                  out_ready;
    logic [`RV_XLEN-1:0]   out_pc;
    logic [`RV_REG_AW-1:0] out_rd;
    logic                  out_we;
    logic [`RV_XLEN-1:0]   out_value;
    logic                  out_redirect;
    logic [`RV_XLEN-1:0]   out_target;
    logic                  out_illegal;

    logic [31:0]           lcg_state;
    logic [`RV_XLEN-1:0]   model_regs [0:31];
    expect_t               exp_q [$];
    int                    errors;
    int                    issued;
    int                    accepted;
    int                    retired;
    logic                  in_fire;
    logic                  out_fire;
    logic                  running;
    logic [`RV_XLEN-1:0]   next_pc;

    rv_exec_top u_rv_exec_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_rd       (out_rd),
        .out_we       (out_we),
        .out_value    (out_value),
        .out_redirect (out_redirect),
        .out_target   (out_target),
        .out_illegal  (out_illegal)
    );

    bind rv_exec_top rv_exec_asserts u_rv_exec_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_value    (out_value),
        .out_target   (out_target),
        .out_rd       (out_rd),
        .out_we       (out_we),
        .out_redirect (out_redirect),
        .out_illegal  (out_illegal)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ============================================================
    // stimulus, registers x0 to x7 only so hazards are common
    // ============================================================
    function automatic logic [`RV_ILEN-1:0] gen_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = lcg_next();
        s   = lcg_next();
        rd  = {2'b00, s[2:0]};
        rs1 = {2'b00, s[5:3]};
        rs2 = {2'b00, s[8:6]};
        f3  = s[11:9];
        f7  = (s[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        case (r[31:28])
            4'd0: return {r[19:0], rd, 7'h37};
            4'd1: return {r[19:0], rd, 7'h17};
            4'd2: return {r[19:0], rd, 7'h6f};
            4'd3: return {r[11:0], rs1, 3'b000, rd, 7'h67};
            4'd4, 4'd5: begin
                // funct3 2 and 3 are no branch
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;
                return {r[6:0], rs2, rs1, f3, r[11:7], 7'h63};
            end
            4'd6, 4'd7, 4'd8, 4'd9: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    return {f7, r[4:0], rs1, f3, rd, 7'h13};
                return {r[11:0], rs1, f3, rd, 7'h13};
            end
            // a load, not supported
            4'd15: return {r[11:0], rs1, 3'b010, rd, 7'h03};
            default: return {f7, rs2, rs1, f3, rd, 7'h33};
        endcase
    endfunction

    always @(posedge clk) begin
        logic [31:0] r;
        if (running) begin
            r = lcg_next();
            out_ready <= r[1:0] != 2'b00;
            if (!in_valid || in_fire) begin
                if (issued < NUM_INSTR && r[4:2] != 3'b000) begin
                    in_valid <= 1'b1;
                    in_instr <= gen_instr();
                    in_pc    <= next_pc;
                    next_pc = next_pc + 32'd4;
                    issued++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // ============================================================
    // reference model, architectural order
    // ============================================================
    function automatic logic [`RV_XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                    input logic [`RV_XLEN-1:0] x,
                                                    input logic [`RV_XLEN-1:0] y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return (x[31] != y[31]) ? {31'b0, x[31]} : {31'b0, x < y};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt && x[31])
                    return ~(~x >> y[4:0]);
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic model_step(input logic [`RV_ILEN-1:0] instr, input logic [`RV_XLEN-1:0] pc);
        expect_t             e;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] imm_i;
        logic [`RV_XLEN-1:0] imm_u;
        logic [`RV_XLEN-1:0] imm_b;
        logic [`RV_XLEN-1:0] imm_j;
        logic [2:0]          f3;
        logic                writes;
        logic                taken;
        f3     = instr[14:12];
        a      = model_regs[instr[19:15]];
        b      = model_regs[instr[24:20]];
        imm_i  = $signed(instr) >>> 20;
        imm_u  = {instr[31:12], 12'h000};
        imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        e      = '0;
        e.pc   = pc;
        e.rd   = instr[11:7];
        writes = 1'b1;
        taken  = 1'b0;
        case (instr[6:0])
            7'h37: e.value = imm_u;
            7'h17: e.value = pc + imm_u;
            7'h6f: begin
                e.value    = pc + 32'd4;
                e.redirect = 1'b1;
                e.target   = pc + imm_j;
            end
            7'h67: begin
                e.value    = pc + 32'd4;
                e.redirect = 1'b1;
                e.target   = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                writes = 1'b0;
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                e.redirect = taken;
                e.target   = pc + imm_b;
            end
            7'h13: e.value = ref_alu(f3, f3 == 3'd5 && instr[30], a, imm_i);
            7'h33: e.value = ref_alu(f3, instr[30], a, b);
            default: begin
                writes    = 1'b0;
                e.illegal = 1'b1;
            end
        endcase
        e.we = writes && e.rd != '0;
        if (e.we)
            model_regs[e.rd] = e.value;
        exp_q.push_back(e);
    endtask

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic check_word(input string what, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_dest(input logic [`RV_REG_AW-1:0] got_rd, input logic got_we,
                              input logic [`RV_REG_AW-1:0] exp_rd, input logic exp_we,
                              input logic [`RV_XLEN-1:0] pc);
        if (got_we !== exp_we || (exp_we && got_rd !== exp_rd)) begin
            errors++;
            $display("MISMATCH at %0t: pc %h writes x%0d we %b, expected x%0d we %b",
                     $time, pc, got_rd, got_we, exp_rd, exp_we);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // sampled mid cycle, the transfer itself happens on the next rising edge
    always @(negedge clk) begin
        expect_t e;
        in_fire  = rst_n && in_valid && in_ready;
        out_fire = rst_n && out_valid && out_ready;
        if (out_fire) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("an output came out at %0t with no instruction pending", $time);
            end else begin
                e = exp_q.pop_front();
                check_word("pc", out_pc, e.pc);
                check_dest(out_rd, out_we, e.rd, e.we, e.pc);
                check_flag($sformatf("redirect of pc %h", e.pc), out_redirect, e.redirect);
                check_flag($sformatf("illegal of pc %h", e.pc), out_illegal, e.illegal);
                if (e.we)
                    check_word($sformatf("value of pc %h", e.pc), out_value, e.value);
                if (e.redirect)
                    check_word($sformatf("target of pc %h", e.pc), out_target, e.target);
            end
            retired++;
        end
        if (in_fire) begin
            model_step(in_instr, in_pc);
            accepted++;
        end
    end

    initial begin
        int wait_cycles;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        out_ready = 1'b0;
        in_fire   = 1'b0;
        out_fire  = 1'b0;
        running   = 1'b0;
        errors    = 0;
        issued    = 0;
        accepted  = 0;
        retired   = 0;
        next_pc   = 32'h0000_1000;
        lcg_state = 32'h0392611c;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_cycles = 0;
        while (!in_ready && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!in_ready) begin
            errors++;
            $display("in_ready never went high after reset");
        end else begin
            running = 1'b1;
            wait_cycles = 0;
            while (retired < NUM_INSTR && wait_cycles < NUM_INSTR * 40) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (retired < NUM_INSTR) begin
                errors++;
                $display("timed out with %0d of %0d instructions out", retired, NUM_INSTR);
            end
            repeat (3) @(negedge clk);
            if (out_valid || exp_q.size() != 0 || accepted != retired) begin
                errors++;
                $display("pipeline not empty after the drain, %0d accepted, %0d out",
                         accepted, retired);
            end
        end
        errors += u_rv_exec_top.u_rv_exec_asserts.fails;
        $display("accepted %0d, retired %0d, errors %0d", accepted, retired, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== rv_exec.f ====
+incdir+.
rv_exec_pkg.sv
rv_exec_if.sv
rv_decode.sv
rv_alu.sv
rv_execute.sv
rv_result.sv
rv_exec_top.sv
rv_exec_asserts.sv
rv_exec_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_exec_pkg.sv
      - rv_exec_if.sv
      - rv_decode.sv
      - rv_alu.sv
      - rv_execute.sv
      - rv_result.sv
      - rv_exec_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - rv_exec_asserts.sv
      - rv_exec_tb.sv
